// File: fpadd_defines.svh
// width and limit macros of the half-precision adder, included by the package and each stage
`ifndef FPADD_DEFINES_SVH
`define FPADD_DEFINES_SVH

// stored format
`define FPADD_FP_WIDTH    16  // whole word, sign + exponent + fraction
`define FPADD_EXP_WIDTH   5   // stored exponent
`define FPADD_FRAC_WIDTH  10  // stored fraction, hidden one not included

// working widths inside the datapath
`define FPADD_EXP_X_WIDTH 6   // exponent plus one headroom bit for borrow / carry
`define FPADD_SIG_X_WIDTH 16  // 2 headroom zeros, hidden one, fraction, guard zeros
`define FPADD_GUARD_BITS  3   // zeros appended below the fraction

// exponent limits
`define FPADD_EXP_SAT     30  // largest finite exponent, carry saturates here
`define FPADD_EXP_SPECIAL 31  // all ones, inf / nan class

// hidden-one position inside the extended significand, derived from the above
`define FPADD_HID_POS     (`FPADD_FRAC_WIDTH + `FPADD_GUARD_BITS)

`endif

// File: fpadd_pkg.sv
// shared types of the half-precision adder, imported by every stage and by the top level
`include "fpadd_defines.svh"

package fpadd_pkg;

    // ieee half precision fields, msb first
    typedef struct packed {
        logic                          sign;  // 1 = negative
        logic [`FPADD_EXP_WIDTH-1:0]   exp;   // biased exponent
        logic [`FPADD_FRAC_WIDTH-1:0]  frac;  // fraction below the hidden one
    } fp16_t;

    // operand / result word, seen as raw bits or as fields
    typedef union packed {
        logic [`FPADD_FP_WIDTH-1:0]    raw;   // bus view
        fp16_t                         f;     // decoded view
    } fp16_u;

    // exponent with one headroom bit, msb flags a negative difference
    typedef logic [`FPADD_EXP_X_WIDTH-1:0] exp_x_t;

    // significand with headroom, hidden one and guard zeros
    typedef logic [`FPADD_SIG_X_WIDTH-1:0] sig_x_t;

endpackage

// File: fpadd_align.sv
// input stage of the fp16 adder: unpacks, compares and aligns both operands, then registers them
`timescale 1ns/1ps
`include "fpadd_defines.svh"

module fpadd_align import fpadd_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  fp16_u                         fp_a,        // first operand
    input  fp16_u                         fp_b,        // second operand
    output sig_x_t                        sig_big,     // larger magnitude significand
    output sig_x_t                        sig_small,   // smaller significand, aligned to sig_big
    output logic                          eff_sub,     // signs differ, subtract
    output logic                          sign_res,    // sign of the result
    output exp_x_t                        exp_big,     // larger exponent
    output logic [1:0]                    special_in,  // [1] any exp all ones, [0] both exp zero
    output logic [`FPADD_FRAC_WIDTH-1:0]  frac_big     // fraction of larger-exponent operand
);

    exp_x_t                        exp_a;        // zero-extended exponents
    exp_x_t                        exp_b;
    exp_x_t                        dif_ab;       // exp_a - exp_b, msb set when negative
    exp_x_t                        dif_ba;       // exp_b - exp_a
    exp_x_t                        exp_dif;      // distance, always positive
    sig_x_t                        sig_a;        // extended significands with hidden one
    sig_x_t                        sig_b;
    sig_x_t                        sig_lo;       // smaller-exponent significand before shift
    sig_x_t                        sft_1;        // log shifter stages
    sig_x_t                        sft_2;
    sig_x_t                        sft_4;
    sig_x_t                        sft_8;
    sig_x_t                        sig_shf;      // aligned smaller significand
    logic                          a_exp_ge;     // exp_a >= exp_b
    logic                          exp_eq;       // exponents equal
    logic                          a_sig_ge;     // sig_a >= sig_b
    logic                          sig_eq;       // significands equal
    logic                          sub_d;        // next-state values of the stage register
    logic                          sign_d;
    logic [1:0]                    special_d;
    sig_x_t                        sig_big_d;
    sig_x_t                        sig_small_d;
    exp_x_t                        exp_big_d;
    logic [`FPADD_FRAC_WIDTH-1:0]  frac_big_d;

    // unpack, hidden one always set, exponent 0 treated like a normal number
    assign exp_a = {1'b0, fp_a.f.exp};
    assign exp_b = {1'b0, fp_b.f.exp};
    assign sig_a = {2'b00, 1'b1, fp_a.f.frac, {`FPADD_GUARD_BITS{1'b0}}};
    assign sig_b = {2'b00, 1'b1, fp_b.f.frac, {`FPADD_GUARD_BITS{1'b0}}};

    assign special_d[0] = ~|exp_a & ~|exp_b;  // both zero exponent
    assign special_d[1] = &fp_a.f.exp | &fp_b.f.exp;  // any all-ones exponent

    // exponent compare, subtract both ways
    assign dif_ab   = exp_a - exp_b;
    assign dif_ba   = exp_b - exp_a;
    assign a_exp_ge = ~dif_ab[`FPADD_EXP_X_WIDTH-1];
    assign exp_eq   = ~|dif_ab;
    assign exp_dif  = a_exp_ge ? dif_ab : dif_ba;

    // magnitude compare, only looked at when exponents are equal
    assign a_sig_ge = (sig_a >= sig_b);
    assign sig_eq   = (sig_a == sig_b);

    // right alignment of the smaller-exponent significand
    assign sig_lo  = a_exp_ge ? sig_b : sig_a;
    assign sft_1   = exp_dif[0] ? sig_lo >> 1 : sig_lo;
    assign sft_2   = exp_dif[1] ? sft_1 >> 2 : sft_1;
    assign sft_4   = exp_dif[2] ? sft_2 >> 4 : sft_2;
    assign sft_8   = exp_dif[3] ? sft_4 >> 8 : sft_4;
    assign sig_shf = (|exp_dif[`FPADD_EXP_X_WIDTH-1:4]) ? '0 : sft_8;  // 16 or more, all gone

    // equal exponents order by significand, else by exponent
    assign sig_big_d   = exp_eq ? (a_sig_ge ? sig_a : sig_b) : (a_exp_ge ? sig_a : sig_b);
    assign sig_small_d = exp_eq ? (a_sig_ge ? sig_b : sig_a) : sig_shf;
    assign exp_big_d   = a_exp_ge ? exp_a : exp_b;
    assign frac_big_d  = a_exp_ge ? fp_a.f.frac : fp_b.f.frac;
    assign sub_d       = fp_a.f.sign ^ fp_b.f.sign;

    // result sign
    always_comb begin
        if (!sub_d) begin
            sign_d = special_d[0] ? 1'b0 : fp_a.f.sign;  // two zero exponents give +
        end else if (exp_eq && sig_eq) begin
            sign_d = 1'b0;  // exact cancellation is +0
        end else if (exp_eq) begin
            sign_d = a_sig_ge ? fp_a.f.sign : fp_b.f.sign;
        end else begin
            sign_d = a_exp_ge ? fp_a.f.sign : fp_b.f.sign;
        end
    end

    // pipeline register, the only state in the adder
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sig_big    <= '0;
            sig_small  <= '0;
            eff_sub    <= 1'b0;
            sign_res   <= 1'b0;
            exp_big    <= '0;
            special_in <= '0;
            frac_big   <= '0;
        end else begin
            sig_big    <= sig_big_d;
            sig_small  <= sig_small_d;
            eff_sub    <= sub_d;
            sign_res   <= sign_d;
            exp_big    <= exp_big_d;
            special_in <= special_d;
            frac_big   <= frac_big_d;
        end
    end

endmodule

// File: fpadd_sig_path.sv
// significand stage of the fp16 adder: adds or subtracts the aligned significands and normalizes
`timescale 1ns/1ps
`include "fpadd_defines.svh"

module fpadd_sig_path import fpadd_pkg::*; (
    input  sig_x_t      sig_big,      // larger magnitude significand
    input  sig_x_t      sig_small,    // aligned smaller significand
    input  logic        eff_sub,      // subtract instead of add
    output sig_x_t      sig_norm,     // hidden one back at its position
    output logic        carry_shift,  // add overflowed, shifted right by one
    output logic [3:0]  lead_shift,   // left shift applied after a subtract
    output logic        sum_zero      // raw sum is zero
);

    localparam int HID_POS = `FPADD_HID_POS;  // bit 13

    sig_x_t      sig_sum;   // raw sum, never negative since big >= small
    logic [3:0]  lead_cnt;  // distance of the leading one below HID_POS
    sig_x_t      sft_1;     // left shifter stages
    sig_x_t      sft_2;
    sig_x_t      sft_4;
    sig_x_t      sft_8;
    sig_x_t      sig_add;   // normalized add result

    // significand add / subtract
    assign sig_sum  = eff_sub ? sig_big - sig_small : sig_big + sig_small;
    assign sum_zero = ~|sig_sum;

    // same-sign sum can only spill into the first headroom bit
    assign carry_shift = ~eff_sub & sig_sum[HID_POS+1];
    assign sig_add     = carry_shift ? sig_sum >> 1 : sig_sum;

    // leading one search, lowest bit first so the highest one wins
    always_comb begin
        lead_cnt = '0;
        for (int i = 0; i <= HID_POS; i++) begin
            if (sig_sum[i]) begin
                lead_cnt = 4'(HID_POS - i);
            end
        end
    end

    assign lead_shift = eff_sub ? lead_cnt : 4'd0;  // no left shift on the add path

    // left normalization, one stage per count bit
    assign sft_1 = lead_shift[0] ? sig_sum << 1 : sig_sum;
    assign sft_2 = lead_shift[1] ? sft_1 << 2 : sft_1;
    assign sft_4 = lead_shift[2] ? sft_2 << 4 : sft_2;
    assign sft_8 = lead_shift[3] ? sft_4 << 8 : sft_4;

    // pick the path for the effective operation
    always_comb begin
        if (eff_sub) begin
            sig_norm = sft_8;    // cancellation fixed up
        end else begin
            sig_norm = sig_add;  // at most one right shift
        end
    end

endmodule

// File: fpadd_pack.sv
// output stage of the fp16 adder: adjusts and saturates the exponent, then packs the result word
`timescale 1ns/1ps
`include "fpadd_defines.svh"

module fpadd_pack import fpadd_pkg::*; (
    input  exp_x_t                        exp_big,      // larger operand exponent
    input  logic                          sign_res,     // result sign from the input stage
    input  logic [1:0]                    special_in,   // [1] any exp all ones
    input  logic [`FPADD_FRAC_WIDTH-1:0]  frac_big,     // fraction passed through for exp 31
    input  sig_x_t                        sig_norm,     // normalized significand
    input  logic                          carry_shift,  // add path shifted right
    input  logic                          eff_sub,      // subtract path active
    input  logic [3:0]                    lead_shift,   // subtract path left shift
    input  logic                          sum_zero,     // zero significand sum
    output fp16_u                         fp_sum        // packed result
);

    localparam int HID_POS = `FPADD_HID_POS;

    exp_x_t  exp_inc;  // add path exponent before saturation
    logic    exp_ovf;  // exp 30 or 31 with a carry
    exp_x_t  exp_add;  // add path, saturated at 30
    exp_x_t  exp_dec;  // sub path, may go negative
    exp_x_t  exp_sub;  // sub path, clamped at 0
    exp_x_t  exp_adj;  // selected adjusted exponent
    fp16_t   res;      // result fields

    // add path, saturation decided from exp_big and the carry only
    assign exp_inc = exp_big + exp_x_t'(carry_shift);
    assign exp_ovf = &{exp_big[`FPADD_EXP_WIDTH-1:1], carry_shift};
    assign exp_add = exp_ovf ? exp_x_t'(`FPADD_EXP_SAT) : exp_inc;

    // subtract path, headroom msb is the borrow
    assign exp_dec = exp_big - exp_x_t'(lead_shift);
    assign exp_sub = exp_dec[`FPADD_EXP_X_WIDTH-1] ? '0 : exp_dec;

    assign exp_adj = eff_sub ? exp_sub : exp_add;

    // packing, all-ones input first, then zero sum
    always_comb begin
        res.sign = sign_res;
        if (special_in[1]) begin
            res.exp  = `FPADD_EXP_WIDTH'(`FPADD_EXP_SPECIAL);
            res.frac = frac_big;  // larger-exponent operand fraction kept
        end else if (sum_zero) begin
            res.exp  = '0;
            res.frac = sig_norm[HID_POS-1 -: `FPADD_FRAC_WIDTH];  // all zero here
        end else begin
            res.exp  = exp_adj[`FPADD_EXP_WIDTH-1:0];
            res.frac = sig_norm[HID_POS-1 -: `FPADD_FRAC_WIDTH];  // chop the guard bits
        end
    end

    assign fp_sum.f = res;

endmodule

// File: fp16_adder.sv
// top level of the pipelined fp16 adder/subtractor, one cycle from operands to fp_sum
`timescale 1ns/1ps
`include "fpadd_defines.svh"

module fp16_adder import fpadd_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  fp16_u  fp_a,    // sampled every rising edge
    input  fp16_u  fp_b,
    output fp16_u  fp_sum   // result of the pair taken on the previous edge
);

    sig_x_t                        sig_big;      // registered, align to sig path
    sig_x_t                        sig_small;
    logic                          eff_sub;      // also used by pack
    logic                          sign_res;     // registered, align to pack
    exp_x_t                        exp_big;
    logic [1:0]                    special_in;
    logic [`FPADD_FRAC_WIDTH-1:0]  frac_big;
    sig_x_t                        sig_norm;     // combinational, sig path to pack
    logic                          carry_shift;
    logic [3:0]                    lead_shift;
    logic                          sum_zero;

    fpadd_align i_align (
        .clk        (clk),
        .rst_n      (rst_n),
        .fp_a       (fp_a),
        .fp_b       (fp_b),
        .sig_big    (sig_big),
        .sig_small  (sig_small),
        .eff_sub    (eff_sub),
        .sign_res   (sign_res),
        .exp_big    (exp_big),
        .special_in (special_in),
        .frac_big   (frac_big)
    );

    fpadd_sig_path i_sig_path (
        .sig_big     (sig_big),
        .sig_small   (sig_small),
        .eff_sub     (eff_sub),
        .sig_norm    (sig_norm),
        .carry_shift (carry_shift),
        .lead_shift  (lead_shift),
        .sum_zero    (sum_zero)
    );

    fpadd_pack i_pack (
        .exp_big     (exp_big),
        .sign_res    (sign_res),
        .special_in  (special_in),
        .frac_big    (frac_big),
        .sig_norm    (sig_norm),
        .carry_shift (carry_shift),
        .eff_sub     (eff_sub),
        .lead_shift  (lead_shift),
        .sum_zero    (sum_zero),
        .fp_sum      (fp_sum)
    );

endmodule

// File: tb_fp16_adder.sv
// self-checking testbench of the fp16 adder that streams a table of operand pairs through the DUT
`timescale 1ns/1ps
`include "fpadd_defines.svh"

module tb_fp16_adder import fpadd_pkg::*; ();

    localparam int CLK_HALF      = 50;  // 100 ns period
    localparam int RESET_CYCLES  = 16;
    localparam int RESET_TIMEOUT = 40;  // cycles allowed until reset is released
    localparam int DRIVE_DLY     = 1;   // stimulus skew after the rising edge
    localparam int NUM_RANDOM    = 8;   // random same-sign, same-exponent pairs

    logic   clk;
    logic   rst_n;
    fp16_u  fp_a;
    fp16_u  fp_b;
    fp16_u  fp_sum;

    logic [`FPADD_FP_WIDTH-1:0] tab_a[$];    // stimulus table for operand a
    logic [`FPADD_FP_WIDTH-1:0] tab_b[$];    // operand b
    logic [`FPADD_FP_WIDTH-1:0] tab_sum[$];  // expected fp_sum one cycle later

    integer seed;
    int     errors;
    int     checks;
    logic   timed_out;

    fp16_adder i_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .fp_a   (fp_a),
        .fp_b   (fp_b),
        .fp_sum (fp_sum)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;  // released just after edge 16
    end

    task automatic check_value(input string name,
                               input logic [`FPADD_FP_WIDTH-1:0] actual,
                               input logic [`FPADD_FP_WIDTH-1:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%04h, expected 0x%04h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic add_entry(input logic [`FPADD_FP_WIDTH-1:0] a,
                             input logic [`FPADD_FP_WIDTH-1:0] b,
                             input logic [`FPADD_FP_WIDTH-1:0] sum);
        tab_a.push_back(a);
        tab_b.push_back(b);
        tab_sum.push_back(sum);
    endtask

    // hand-computed entries chopped to 10 fraction bits
    task automatic load_table();
        add_entry(16'h0000, 16'h0000, 16'h0400);  // exp 0 keeps a hidden one so 2^-15 + 2^-15
        add_entry(16'h8000, 16'h8000, 16'h0400);  // two zero exponents give + even when negative
        add_entry(16'h3C00, 16'h3C00, 16'h4000);  // 1 + 1 with carry
        add_entry(16'h3E00, 16'h3C00, 16'h4100);  // 1.5 + 1 = 2.5
        add_entry(16'hBC00, 16'hBC00, 16'hC000);  // sign of a kept
        add_entry(16'h4200, 16'h3800, 16'h4300);  // 3 + 0.5 with a shift by 2
        add_entry(16'h3C01, 16'h3401, 16'h3D01);  // 2^-12 chopped
        add_entry(16'h3C01, 16'h3C00, 16'h4000);  // carry drops the low bit
        add_entry(16'h4000, 16'hBC00, 16'h3C00);  // 2 - 1
        add_entry(16'h3C00, 16'hC000, 16'hBC00);  // b larger so the result is negative
        add_entry(16'h3C00, 16'hBE00, 16'hB800);  // same exp with b larger
        add_entry(16'h3C01, 16'hBC00, 16'h1400);  // cancellation needs a left shift of 10
        add_entry(16'hBC00, 16'h3C01, 16'h1400);  // same with operands swapped
        add_entry(16'h4000, 16'hB401, 16'h3EFF);  // 1.75 - 2^-12 chopped
        add_entry(16'h3C00, 16'hBC00, 16'h0000);  // exact cancellation
        add_entry(16'hBC00, 16'h3C00, 16'h0000);
        add_entry(16'hC500, 16'h4500, 16'h0000);
        add_entry(16'h7C00, 16'h3C00, 16'h7C00);  // exp 31 forces exp 31
        add_entry(16'h3C00, 16'h7E00, 16'h7E00);  // fraction of the larger-exp operand
        add_entry(16'hFC00, 16'h3C00, 16'hFC00);
        add_entry(16'h7800, 16'h7800, 16'h7800);  // carry at exp 30 saturates
        add_entry(16'h0401, 16'h8400, 16'h0000);  // exponent clamps at 0
    endtask

    // with equal sign and exponent 1.fa + 1.fb is always >= 2 so the exponent
    // rises by one and the fraction is the halved fraction sum
    task automatic add_random_pairs(input int count);
        logic [31:0] r;
        logic        s;
        int          e;
        int          fa;
        int          fb;
        int          fs;
        for (int k = 0; k < count; k++) begin
            r  = $random(seed);
            s  = r[31];
            e  = int'(r[4:0]) % 29 + 1;  // 1..29 keeps clear of saturation
            fa = int'(r[14:5]);
            fb = int'(r[24:15]);
            fs = (fa + fb) / 2;          // chopped
            add_entry({s, 5'(e), 10'(fa)}, {s, 5'(e), 10'(fb)}, {s, 5'(e + 1), 10'(fs)});
        end
    endtask

    initial begin
        int cycles;
        int n;
        fp_a.raw  = '0;
        fp_b.raw  = '0;
        seed      = 32'hf2cea772;
        errors    = 0;
        checks    = 0;
        timed_out = 1'b0;
        load_table();
        add_random_pairs(NUM_RANDOM);

        // output must read zero for the whole reset
        cycles = 0;
        while (!rst_n && cycles < RESET_TIMEOUT) begin
            @(negedge clk);
            if (!rst_n) begin
                check_value("fp_sum during reset", fp_sum.raw, 16'h0000);
            end
            cycles++;
        end
        if (!rst_n) begin
            $display("timeout: reset was not released within %0d cycles", RESET_TIMEOUT);
            errors++;
            timed_out = 1'b1;
        end else begin
            check_value("fp_sum after reset release", fp_sum.raw, 16'h0000);  // no edge yet
        end

        // one pair per cycle with the result checked at the following negedge
        if (!timed_out) begin
            n = tab_a.size();
            for (int i = 0; i <= n; i++) begin
                @(posedge clk);
                #DRIVE_DLY;
                if (i < n) begin
                    fp_a.raw = tab_a[i];
                    fp_b.raw = tab_b[i];
                end else begin
                    fp_a.raw = '0;
                    fp_b.raw = '0;
                end
                @(negedge clk);  // register holds entry i-1 now
                if (i > 0) begin
                    check_value($sformatf("fp_sum entry %0d", i - 1), fp_sum.raw, tab_sum[i - 1]);
                end
            end
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+.
fpadd_pkg.sv
fpadd_align.sv
fpadd_sig_path.sv
fpadd_pack.sv
fp16_adder.sv
tb_fp16_adder.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
LINTFLAGS = --lint-only -Wall --timing
TOP       = tb_fp16_adder
FILELIST  = list.f
OBJ_DIR   = obj_dir
PASS_MSG  = Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# status comes from grep, so a missing pass line fails the target
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
